/* dotp_pkg.sv */
package dotp_pkg;

  // --------------------
  // Format constants
  // --------------------
  // Half precision, 1 sign, 5 exponent and 10 mantissa bits
  localparam int unsigned EXP_BITS = 5;
  localparam int unsigned MAN_BITS = 10;
  localparam int unsigned WIDTH    = 1 + EXP_BITS + MAN_BITS;
  localparam int unsigned BIAS     = 15;

  // Precision with the implicit bit
  localparam int unsigned PREC_BITS   = MAN_BITS + 1;
  // Aligned sum, 4p+4 bits including round and sticky slots
  localparam int unsigned SUM_WIDTH   = 4 * PREC_BITS + 4;
  // Signed internal exponent, room for product exponents and LZC
  localparam int unsigned EXP_WIDTH   = EXP_BITS + 2;
  // Alignment and normalization shifts reach up to SUM_WIDTH
  localparam int unsigned SHAMT_WIDTH = $clog2(SUM_WIDTH + 1);

  // Canonical quiet NaN
  localparam logic [WIDTH-1:0] QNAN = {1'b0, {EXP_BITS{1'b1}}, 1'b1, {(MAN_BITS-1){1'b0}}};

  // --------------------
  // Types
  // --------------------
  typedef enum logic {
    RNE = 1'b0,
    RTZ = 1'b1
  } roundmode_e;

  // IEEE exception flags, NV in the MSB
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // Decode to execute
  typedef struct packed {
    logic [3:0][PREC_BITS-1:0]   mant;
    logic                        eff_sub;
    logic                        tent_sign;
    logic signed [EXP_WIDTH-1:0] exp_prod_x;
    logic signed [EXP_WIDTH-1:0] exp_diff;
    logic signed [EXP_WIDTH-1:0] tent_exp;
    logic [SHAMT_WIDTH-1:0]      addend_shamt;
    roundmode_e                  rnd_mode;
    logic                        is_special;
    logic [WIDTH-1:0]            special_result;
    status_t                     special_status;
  } dec_pld_t;

  // Execute to result
  typedef struct packed {
    logic [SUM_WIDTH-1:0]        sum;
    logic                        sticky_before_add;
    logic                        final_sign;
    logic signed [EXP_WIDTH-1:0] exp_prod_x;
    logic signed [EXP_WIDTH-1:0] exp_diff;
    logic signed [EXP_WIDTH-1:0] tent_exp;
    logic [SHAMT_WIDTH-1:0]      addend_shamt;
    logic                        eff_sub;
    roundmode_e                  rnd_mode;
    logic                        is_special;
    logic [WIDTH-1:0]            special_result;
    status_t                     special_status;
  } exe_pld_t;

  // Final result
  typedef struct packed {
    logic [WIDTH-1:0] result;
    status_t          status;
  } out_pld_t;

endpackage

/* dotp_stage_reg.sv */
`timescale 1ns/100ps

module dotp_stage_reg #(
  parameter type         payload_t = logic,
  parameter int unsigned TagWidth  = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Upstream side
  input  logic                valid_i,
  output logic                ready_o,
  input  payload_t            pld_i,
  input  logic [TagWidth-1:0] tag_i,
  // Downstream side
  output logic                valid_o,
  input  logic                ready_i,
  output payload_t            pld_o,
  output logic [TagWidth-1:0] tag_o
);

  logic                valid_q;
  payload_t            pld_q;
  logic [TagWidth-1:0] tag_q;

  // Free slot, or the current item leaves this cycle
  assign ready_o = ready_i | ~valid_q;

  // Only the valid bit is control state
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Capture data on an accepted handshake only
  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      pld_q <= pld_i;
      tag_q <= tag_i;
    end
  end

  assign valid_o = valid_q;
  assign pld_o   = pld_q;
  assign tag_o   = tag_q;

endmodule

/* dotp_decode.sv */
`timescale 1ns/100ps

module dotp_decode (
  input  logic [3:0][dotp_pkg::WIDTH-1:0] operands_i,
  input  logic                            op_mod_i,
  input  dotp_pkg::roundmode_e            rnd_mode_i,
  output dotp_pkg::dec_pld_t              pld_o
);

  localparam int EB   = dotp_pkg::EXP_BITS;
  localparam int MB   = dotp_pkg::MAN_BITS;
  localparam int P    = dotp_pkg::PREC_BITS;
  localparam int EW   = dotp_pkg::EXP_WIDTH;
  localparam int SHW  = dotp_pkg::SHAMT_WIDTH;
  localparam int BIAS = dotp_pkg::BIAS;

  // --------------------
  // Classification
  // --------------------
  logic [3:0]         op_sign;
  logic [3:0][EB-1:0] exp_f;
  logic [3:0][MB-1:0] man_f;
  logic [3:0]         is_zero, is_inf, is_nan, is_snan, is_normal;
  logic [3:0][P-1:0]  mant;

  always_comb begin : classify
    for (int i = 0; i < 4; i++) begin
      op_sign[i]   = operands_i[i][dotp_pkg::WIDTH-1];
      exp_f[i]     = operands_i[i][dotp_pkg::WIDTH-2 -: EB];
      man_f[i]     = operands_i[i][MB-1:0];
      // Subnormals land here too and count as zero
      is_zero[i]   = (exp_f[i] == '0);
      is_inf[i]    = (exp_f[i] == '1) && (man_f[i] == '0);
      is_nan[i]    = (exp_f[i] == '1) && (man_f[i] != '0);
      // Quiet bit is the mantissa MSB
      is_snan[i]   = is_nan[i] && !man_f[i][MB-1];
      is_normal[i] = !is_zero[i] && (exp_f[i] != '1);
      mant[i]      = is_normal[i] ? {1'b1, man_f[i]} : '0;
    end
    // DOTPN negates c and with it the second product
    op_sign[2] = op_sign[2] ^ op_mod_i;
  end

  // Product-level view
  logic sign_x, sign_y, inf_x, inf_y, zero_x, zero_y;
  logic eff_sub;

  assign sign_x  = op_sign[0] ^ op_sign[1];
  assign sign_y  = op_sign[2] ^ op_sign[3];
  assign inf_x   = is_inf[0] | is_inf[1];
  assign inf_y   = is_inf[2] | is_inf[3];
  assign zero_x  = is_zero[0] | is_zero[1];
  assign zero_y  = is_zero[2] | is_zero[3];
  // Products of opposite sign mean a subtraction
  assign eff_sub = sign_x ^ sign_y;

  // --------------------
  // Special cases
  // --------------------
  logic                    is_special;
  logic [dotp_pkg::WIDTH-1:0] special_result;
  dotp_pkg::status_t       special_status;

  always_comb begin : special_cases
    special_result = dotp_pkg::QNAN;
    special_status = '0;
    is_special     = 1'b0;
    // inf*0 is invalid even next to a quiet NaN
    if ((inf_x && zero_x) || (inf_y && zero_y)) begin
      is_special        = 1'b1;
      special_status.NV = 1'b1;
    end else if (|is_nan) begin
      is_special        = 1'b1;
      special_status.NV = |is_snan;
    end else if (inf_x || inf_y) begin
      is_special = 1'b1;
      if (inf_x && inf_y && eff_sub) begin
        special_status.NV = 1'b1;  // inf - inf
      end else if (inf_x) begin
        special_result = {sign_x, {EB{1'b1}}, {MB{1'b0}}};
      end else begin
        special_result = {sign_y, {EB{1'b1}}, {MB{1'b0}}};
      end
    end
  end

  // --------------------
  // Exponent path
  // --------------------
  logic signed [EW-1:0] exp_x, exp_y, exp_diff, tent_exp;
  logic [SHW-1:0]       addend_shamt;

  // Biased product exponents, zero products pinned to the minimum
  assign exp_x = zero_x ? EW'(2 - BIAS) : EW'(int'(exp_f[0]) + int'(exp_f[1]) - BIAS);
  assign exp_y = zero_y ? EW'(2 - BIAS) : EW'(int'(exp_f[2]) + int'(exp_f[3]) - BIAS);

  assign exp_diff = exp_y - exp_x;
  assign tent_exp = (exp_diff > 0) ? exp_y : exp_x;

  always_comb begin : align_shift
    if (exp_diff <= -2 * P - 1) begin
      // Second product only reaches the sticky bit
      addend_shamt = SHW'(4 * P + 4);
    end else if (exp_diff <= 2 * P + 2) begin
      addend_shamt = SHW'(2 * P + 2 - int'(exp_diff));
    end else begin
      // Second product anchors the sum
      addend_shamt = '0;
    end
  end

  always_comb begin : pack_payload
    pld_o.mant           = mant;
    pld_o.eff_sub        = eff_sub;
    pld_o.tent_sign      = sign_x;
    pld_o.exp_prod_x     = exp_x;
    pld_o.exp_diff       = exp_diff;
    pld_o.tent_exp       = tent_exp;
    pld_o.addend_shamt   = addend_shamt;
    pld_o.rnd_mode       = rnd_mode_i;
    pld_o.is_special     = is_special;
    pld_o.special_result = special_result;
    pld_o.special_status = special_status;
  end

endmodule

/* dotp_execute.sv */
`timescale 1ns/100ps

module dotp_execute (
  input  dotp_pkg::dec_pld_t pld_i,
  output dotp_pkg::exe_pld_t pld_o
);

  localparam int P  = dotp_pkg::PREC_BITS;
  localparam int SW = dotp_pkg::SUM_WIDTH;

  // --------------------
  // Products
  // --------------------
  logic [2*P-1:0] prod_x, prod_y;
  logic [SW-1:0]  prod_x_sh;

  assign prod_x = pld_i.mant[0] * pld_i.mant[1];
  assign prod_y = pld_i.mant[2] * pld_i.mant[3];

  // First product sits above the round and sticky slots
  assign prod_x_sh = SW'(prod_x) << 2;

  // --------------------
  // Alignment
  // --------------------
  logic [SW-1:0] addend_al;
  logic [P-1:0]  addend_stk;
  logic          sticky;
  logic [SW-1:0] addend;
  logic          inject_carry;

  // Second product starts at the top, up to p bits fall into the sticky field
  assign {addend_al, addend_stk} = {prod_y, {(3*P+4){1'b0}}} >> pld_i.addend_shamt;
  assign sticky = |addend_stk;

  // One's complement here, the +1 comes in as carry unless bits were lost
  assign addend       = pld_i.eff_sub ? ~addend_al : addend_al;
  assign inject_carry = pld_i.eff_sub & ~sticky;

  // --------------------
  // Adder
  // --------------------
  logic [SW:0]   sum_raw;
  logic          carry;
  logic [SW-1:0] sum;
  logic          final_sign;

  assign sum_raw = {1'b0, prod_x_sh} + {1'b0, addend} + (SW+1)'(inject_carry);
  assign carry   = sum_raw[SW];

  // No carry in a subtraction means the result went negative
  assign sum = (pld_i.eff_sub && !carry) ? -sum_raw[SW-1:0] : sum_raw[SW-1:0];
  assign final_sign = pld_i.eff_sub ? (pld_i.tent_sign ^ ~carry) : pld_i.tent_sign;

  always_comb begin : pack_payload
    pld_o.sum               = sum;
    pld_o.sticky_before_add = sticky;
    pld_o.final_sign        = final_sign;
    pld_o.exp_prod_x        = pld_i.exp_prod_x;
    pld_o.exp_diff          = pld_i.exp_diff;
    pld_o.tent_exp          = pld_i.tent_exp;
    pld_o.addend_shamt      = pld_i.addend_shamt;
    pld_o.eff_sub           = pld_i.eff_sub;
    pld_o.rnd_mode          = pld_i.rnd_mode;
    pld_o.is_special        = pld_i.is_special;
    pld_o.special_result    = pld_i.special_result;
    pld_o.special_status    = pld_i.special_status;
  end

endmodule

/* dotp_result.sv */
`timescale 1ns/100ps

module dotp_result (
  input  dotp_pkg::exe_pld_t pld_i,
  output dotp_pkg::out_pld_t pld_o
);

  localparam int P   = dotp_pkg::PREC_BITS;
  localparam int EB  = dotp_pkg::EXP_BITS;
  localparam int MB  = dotp_pkg::MAN_BITS;
  localparam int EW  = dotp_pkg::EXP_WIDTH;
  localparam int SHW = dotp_pkg::SHAMT_WIDTH;
  localparam int SW  = dotp_pkg::SUM_WIDTH;
  // Lower 2p+3 sum bits hold every product-anchored or cancelling result
  localparam int LW  = 2 * P + 3;
  localparam int LZW = $clog2(LW + 1);
  // Two spare bits above the sum catch addend-anchored carries
  localparam int NW  = SW + 2;

  // --------------------
  // Leading zero count
  // --------------------
  logic [LZW-1:0] lzc;

  always_comb begin : lead_zero_count
    logic found;
    found = 1'b0;
    lzc   = '0;
    for (int i = LW - 1; i >= 0; i--) begin
      if (!found) begin
        if (pld_i.sum[i]) found = 1'b1;
        else lzc = lzc + 1'b1;
      end
    end
  end

  // --------------------
  // Normalization
  // --------------------
  logic                 prod_anchored;
  logic [SHW-1:0]       norm_shamt;
  logic signed [EW-1:0] norm_exp;
  logic [NW-1:0]        sh;

  assign prod_anchored = (pld_i.exp_diff <= 0)
                         || (pld_i.eff_sub && (pld_i.exp_diff <= 2) && !pld_i.sum[LW]);

  always_comb begin : norm_shift_amount
    if (prod_anchored) begin
      // Leading one to bit SW-1, bit 2p is the unit of the first product
      norm_shamt = SHW'(SW - LW + int'(lzc));
      norm_exp   = EW'(int'(pld_i.exp_prod_x) + (LW - 1 - 2 * P) - int'(lzc));
    end else begin
      // Undo the alignment, second product unit lands on bit SW-1
      norm_shamt = pld_i.addend_shamt + 1'b1;
      norm_exp   = pld_i.tent_exp;
    end
  end

  assign sh = {2'b00, pld_i.sum} << norm_shamt;

  // Small fix-up, leading one sits within two bits of SW-1
  logic [P:0]           mant_w;
  logic                 sticky_w;
  logic signed [EW-1:0] final_exp;

  always_comb begin : small_norm
    if (sh[NW-1]) begin
      mant_w    = sh[NW-1 -: P+1];
      sticky_w  = |sh[NW-P-2:0];
      final_exp = norm_exp + EW'(2);
    end else if (sh[NW-2]) begin
      mant_w    = sh[NW-2 -: P+1];
      sticky_w  = |sh[NW-P-3:0];
      final_exp = norm_exp + EW'(1);
    end else if (sh[NW-3]) begin
      mant_w    = sh[NW-3 -: P+1];
      sticky_w  = |sh[NW-P-4:0];
      final_exp = norm_exp;
    end else begin
      // Cancellation left of the anchor
      mant_w    = sh[NW-4 -: P+1];
      sticky_w  = |sh[NW-P-5:0];
      final_exp = norm_exp - EW'(1);
    end
  end

  // --------------------
  // Rounding
  // --------------------
  logic sum_zero, flushed, of_before, of_after;
  logic [EB-1:0]    pre_exp;
  logic [MB-1:0]    pre_man;
  logic             round_bit, sticky_bit, round_up;
  logic [EB+MB-1:0] rounded_abs;
  logic             res_sign;
  dotp_pkg::status_t reg_status;

  assign sum_zero  = (pld_i.sum == '0);
  assign flushed   = !sum_zero && (final_exp <= 0);
  assign of_before = !sum_zero && (final_exp >= 2**EB - 1);

  always_comb begin : pre_round
    if (of_before) begin
      // Largest normal, round and sticky forced
      pre_exp    = EB'(2**EB - 2);
      pre_man    = '1;
      round_bit  = 1'b1;
      sticky_bit = 1'b1;
    end else if (flushed || sum_zero) begin
      pre_exp    = '0;
      pre_man    = '0;
      round_bit  = 1'b0;
      sticky_bit = 1'b0;
    end else begin
      pre_exp    = final_exp[EB-1:0];
      pre_man    = mant_w[MB:1];
      round_bit  = mant_w[0];
      sticky_bit = sticky_w | pld_i.sticky_before_add;
    end
  end

  // RNE ties go to even, RTZ never rounds up
  assign round_up    = (pld_i.rnd_mode == dotp_pkg::RNE) && round_bit && (sticky_bit || pre_man[0]);
  assign rounded_abs = {pre_exp, pre_man} + (EB+MB)'(round_up);
  assign of_after    = (rounded_abs[EB+MB-1 -: EB] == '1);
  // x - x gives +0
  assign res_sign    = (sum_zero && pld_i.eff_sub) ? 1'b0 : pld_i.final_sign;

  assign reg_status.NV = 1'b0;
  assign reg_status.DZ = 1'b0;
  assign reg_status.OF = of_before | of_after;
  assign reg_status.UF = flushed;
  assign reg_status.NX = round_bit | sticky_bit | of_before | of_after | flushed;

  assign pld_o.result = pld_i.is_special ? pld_i.special_result : {res_sign, rounded_abs};
  assign pld_o.status = pld_i.is_special ? pld_i.special_status : reg_status;

endmodule

/* dotp_top.sv */
`timescale 1ns/100ps

module dotp_top #(
  parameter int unsigned TagWidth = 4
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // Input handshake
  input  logic                            in_valid_i,
  output logic                            in_ready_o,
  // Operands, a in slot 0
  input  logic [3:0][dotp_pkg::WIDTH-1:0] operands_i,
  input  logic                            op_mod_i,
  input  dotp_pkg::roundmode_e            rnd_mode_i,
  input  logic [TagWidth-1:0]             tag_i,
  // Result
  output logic [dotp_pkg::WIDTH-1:0]      result_o,
  output dotp_pkg::status_t               status_o,
  output logic [TagWidth-1:0]             tag_o,
  // Output handshake
  output logic                            out_valid_o,
  input  logic                            out_ready_i
);

  dotp_pkg::dec_pld_t  dec_pld, dec_pld_q;
  dotp_pkg::exe_pld_t  exe_pld, exe_pld_q;
  dotp_pkg::out_pld_t  out_pld, out_pld_q;
  logic                dec_valid_q, exe_valid_q;
  logic                exe_ready, res_ready;
  logic [TagWidth-1:0] dec_tag_q, exe_tag_q;

  // --------------------
  // Decode stage
  // --------------------
  dotp_decode u_decode (
    .operands_i (operands_i),
    .op_mod_i   (op_mod_i),
    .rnd_mode_i (rnd_mode_i),
    .pld_o      (dec_pld)
  );

  dotp_stage_reg #(.payload_t(dotp_pkg::dec_pld_t), .TagWidth(TagWidth)) u_reg_dec (
    .clk_i, .rst_n_i,
    .valid_i (in_valid_i),  .ready_o (in_ready_o), .pld_i (dec_pld),   .tag_i (tag_i),
    .valid_o (dec_valid_q), .ready_i (exe_ready),  .pld_o (dec_pld_q), .tag_o (dec_tag_q)
  );

  // --------------------
  // Execute stage
  // --------------------
  dotp_execute u_execute (
    .pld_i (dec_pld_q),
    .pld_o (exe_pld)
  );

  dotp_stage_reg #(.payload_t(dotp_pkg::exe_pld_t), .TagWidth(TagWidth)) u_reg_exe (
    .clk_i, .rst_n_i,
    .valid_i (dec_valid_q), .ready_o (exe_ready), .pld_i (exe_pld),   .tag_i (dec_tag_q),
    .valid_o (exe_valid_q), .ready_i (res_ready), .pld_o (exe_pld_q), .tag_o (exe_tag_q)
  );

  // --------------------
  // Result stage
  // --------------------
  dotp_result u_result (
    .pld_i (exe_pld_q),
    .pld_o (out_pld)
  );

  // Last register faces the consumer
  dotp_stage_reg #(.payload_t(dotp_pkg::out_pld_t), .TagWidth(TagWidth)) u_reg_out (
    .clk_i, .rst_n_i,
    .valid_i (exe_valid_q), .ready_o (res_ready),   .pld_i (out_pld),   .tag_i (exe_tag_q),
    .valid_o (out_valid_o), .ready_i (out_ready_i), .pld_o (out_pld_q), .tag_o (tag_o)
  );

  assign result_o = out_pld_q.result;
  assign status_o = out_pld_q.status;

endmodule

/* dotp_props.sv */
`timescale 1ns/100ps

module dotp_props #(
  parameter int unsigned TagWidth = 4
) (
  input logic                       clk_i,
  input logic                       rst_n_i,
  input logic [dotp_pkg::WIDTH-1:0] result_o,
  input dotp_pkg::status_t          status_o,
  input logic [TagWidth-1:0]        tag_o,
  input logic                       out_valid_o,
  input logic                       out_ready_i
);

  // Failed assertions so far
  int unsigned fail_cnt = 0;

  // Pipeline comes out of reset empty
  assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_o)
    else begin
      $error("out_valid_o is high right after reset");
      fail_cnt++;
    end

  // Stalled output holds its data
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> $stable(result_o) && $stable(status_o) && $stable(tag_o))
    else begin
      $error("output data changed while stalled");
      fail_cnt++;
    end

  // No item is withdrawn before the handshake
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o)
    else begin
      $error("out_valid_o dropped before the handshake");
      fail_cnt++;
    end

endmodule

bind dotp_top dotp_props #(.TagWidth(TagWidth)) u_props (
  .clk_i, .rst_n_i, .result_o, .status_o, .tag_o, .out_valid_o, .out_ready_i
);

/* tb_dotp.sv */
`timescale 1ns/100ps

module tb_dotp;

  localparam int TW  = 4;
  // Cycles any single wait may take
  localparam int TMO = 50;

  localparam dotp_pkg::status_t ST_NONE = 5'b00000;
  localparam dotp_pkg::status_t ST_NV   = 5'b10000;

  logic                 clk_i = 1'b0;
  logic                 rst_n_i;
  logic                 in_valid_i, in_ready_o;
  logic [3:0][15:0]     operands_i;
  logic                 op_mod_i;
  dotp_pkg::roundmode_e rnd_mode_i;
  logic [TW-1:0]        tag_i, tag_o;
  logic [15:0]          result_o;
  dotp_pkg::status_t    status_o;
  logic                 out_valid_o, out_ready_i;

  integer        seed     = 32'hf7df;
  int            err_cnt  = 0;
  int            tmo_cnt  = 0;
  logic [TW-1:0] next_tag = '0;

  dotp_top #(.TagWidth(TW)) dut (
    .clk_i, .rst_n_i, .in_valid_i, .in_ready_o, .operands_i, .op_mod_i, .rnd_mode_i,
    .tag_i, .result_o, .status_o, .tag_o, .out_valid_o, .out_ready_i
  );

  always #50 clk_i = ~clk_i;

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_result(input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
      $display("ERR result_o expected %h got %h", exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_status(input dotp_pkg::status_t exp, input dotp_pkg::status_t act);
    if (act !== exp) begin
      $display("ERR status_o expected %h got %h", exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_tag(input logic [TW-1:0] exp, input logic [TW-1:0] act);
    if (act !== exp) begin
      $display("ERR tag_o expected %h got %h", exp, act);
      err_cnt++;
    end
  endtask

  // --------------------
  // Reference model
  // --------------------
  // Exact integer rounded to 11 significant bits, then packed as half
  task automatic round_model(input int v, input dotp_pkg::roundmode_e rm,
                             output logic [15:0] res, output dotp_pkg::status_t st);
    int   m, e, sh, kept, rem, half;
    logic sgn;
    st  = ST_NONE;
    sgn = (v < 0);
    m   = sgn ? -v : v;
    if (m == 0) begin
      res = 16'h0000;
      return;
    end
    e = 0;
    while ((m >> (e + 1)) != 0) e++;
    if (e > 10) begin
      sh   = e - 10;
      kept = m >> sh;
      rem  = m - (kept << sh);
      half = 1 << (sh - 1);
      st.NX = (rem != 0);
      // Ties go to the even neighbour
      if (rm == dotp_pkg::RNE && (rem > half || (rem == half && (kept % 2) == 1))) kept++;
      if (kept == 2048) begin
        kept = 1024;
        e++;
      end
    end else begin
      kept = m << (10 - e);
    end
    if (e + 15 >= 31) begin
      st.OF = 1'b1;
      st.NX = 1'b1;
      res   = (rm == dotp_pkg::RNE) ? {sgn, 15'h7C00} : {sgn, 15'h7BFF};
    end else begin
      res = {sgn, 5'(e + 15), 10'(kept)};
    end
  endtask

  task automatic encode_ops(input int a, input int b, input int c, input int d,
                            output logic [3:0][15:0] ops);
    dotp_pkg::status_t dummy;
    round_model(a, dotp_pkg::RNE, ops[0], dummy);
    round_model(b, dotp_pkg::RNE, ops[1], dummy);
    round_model(c, dotp_pkg::RNE, ops[2], dummy);
    round_model(d, dotp_pkg::RNE, ops[3], dummy);
  endtask

  // --------------------
  // Drive and collect
  // --------------------
  task automatic send_item(input logic [3:0][15:0] ops, input logic mod,
                           input dotp_pkg::roundmode_e rm, input logic [TW-1:0] tag);
    logic accepted;
    @(negedge clk_i);
    operands_i = ops;
    op_mod_i   = mod;
    rnd_mode_i = rm;
    tag_i      = tag;
    in_valid_i = 1'b1;
    accepted   = 1'b0;
    for (int n = 0; n < TMO && !accepted; n++) begin
      @(posedge clk_i);
      accepted = in_ready_o;
    end
    if (!accepted) begin
      $display("Timeout: the DUT never accepted an input item");
      tmo_cnt++;
    end
  endtask

  task automatic wait_output(output logic [15:0] res, output dotp_pkg::status_t st,
                             output logic [TW-1:0] tag, output logic ok);
    ok = 1'b0;
    for (int n = 0; n < TMO && !ok; n++) begin
      @(posedge clk_i);
      if (out_valid_o && out_ready_i) begin
        ok  = 1'b1;
        res = result_o;
        st  = status_o;
        tag = tag_o;
      end
    end
    if (!ok) begin
      $display("Timeout: no result came out of the DUT");
      tmo_cnt++;
    end
  endtask

  // One item through the empty pipeline
  task automatic run_check(input logic [3:0][15:0] ops, input logic mod,
                           input dotp_pkg::roundmode_e rm, input logic [15:0] exp_res,
                           input dotp_pkg::status_t exp_st);
    logic [TW-1:0]     tag, got_tag;
    logic [15:0]       res;
    dotp_pkg::status_t st;
    logic              ok;
    tag = next_tag;
    next_tag++;
    send_item(ops, mod, rm, tag);
    @(negedge clk_i);
    in_valid_i = 1'b0;
    wait_output(res, st, got_tag, ok);
    if (ok) begin
      check_result(exp_res, res);
      check_status(exp_st, st);
      check_tag(tag, got_tag);
    end
  endtask

  // Integer operands, expected value from the model
  task automatic run_int(input int a, input int b, input int c, input int d,
                         input logic mod, input dotp_pkg::roundmode_e rm);
    logic [3:0][15:0]  ops;
    logic [15:0]       exp_res;
    dotp_pkg::status_t exp_st;
    encode_ops(a, b, c, d, ops);
    round_model(a * b + (mod ? -(c * d) : c * d), rm, exp_res, exp_st);
    run_check(ops, mod, rm, exp_res, exp_st);
  endtask

  // --------------------
  // Directed tests
  // --------------------
  task automatic test_exact_random();
    int a, b, c, d;
    for (int i = 0; i < 12; i++) begin
      a = $unsigned($random(seed)) % 32;
      b = $unsigned($random(seed)) % 32;
      c = $unsigned($random(seed)) % 32;
      d = $unsigned($random(seed)) % 32;
      run_int(a, b, c, d, 1'(i % 2), dotp_pkg::roundmode_e'((i / 2) % 2));
    end
  endtask

  task automatic test_dotpn();
    run_int(3, 4, 6, 2, 1'b1, dotp_pkg::RNE);
    run_int(5, 2, 1, 3, 1'b1, dotp_pkg::RNE);
  endtask

  task automatic test_rounding();
    run_int(2048, 1, 1, 3, 1'b0, dotp_pkg::RNE);
    run_int(2048, 1, 1, 3, 1'b0, dotp_pkg::RTZ);
    run_int(2048, 1, 1, 1, 1'b0, dotp_pkg::RNE);
    run_int(2048, 1, 1, 1, 1'b0, dotp_pkg::RTZ);
  endtask

  task automatic test_specials();
    // Slots are {d, c, b, a}
    run_check({16'h3C00, 16'h3C00, 16'h0000, 16'h7C00}, 1'b0, dotp_pkg::RNE,
              16'h7E00, ST_NV);
    run_check({16'h3C00, 16'h3C00, 16'h3C00, 16'h7E00}, 1'b0, dotp_pkg::RNE,
              16'h7E00, ST_NONE);
    run_check({16'h3C00, 16'h3C00, 16'h3C00, 16'h7C01}, 1'b0, dotp_pkg::RNE,
              16'h7E00, ST_NV);
    run_check({16'h3C00, 16'h7C00, 16'h3C00, 16'h7C00}, 1'b1, dotp_pkg::RNE,
              16'h7E00, ST_NV);
    run_check({16'h4200, 16'h4000, 16'hBC00, 16'h7C00}, 1'b0, dotp_pkg::RNE,
              16'hFC00, ST_NONE);
  endtask

  task automatic test_overflow();
    run_int(32768, 4, 0, 0, 1'b0, dotp_pkg::RNE);
    run_int(32768, 4, 0, 0, 1'b0, dotp_pkg::RTZ);
  endtask

  task automatic test_backpressure();
    logic [3:0][15:0]  ops [8];
    logic [15:0]       exp_res [8];
    dotp_pkg::status_t exp_st [8];
    logic [TW-1:0]     tags [8];
    int                a, b, c, d, n_out, cyc;
    for (int i = 0; i < 8; i++) begin
      a = $unsigned($random(seed)) % 32;
      b = $unsigned($random(seed)) % 32;
      c = $unsigned($random(seed)) % 32;
      d = $unsigned($random(seed)) % 32;
      encode_ops(a, b, c, d, ops[i]);
      round_model(a * b + c * d, dotp_pkg::RNE, exp_res[i], exp_st[i]);
      tags[i] = next_tag;
      next_tag++;
    end
    n_out = 0;
    fork
      begin
        for (int i = 0; i < 8; i++) send_item(ops[i], 1'b0, dotp_pkg::RNE, tags[i]);
        @(negedge clk_i);
        in_valid_i = 1'b0;
      end
      begin
        // Consumer stalls first, then takes items at random
        for (cyc = 0; cyc < 4 * TMO && n_out < 8; cyc++) begin
          @(negedge clk_i);
          out_ready_i = (cyc < 6) ? 1'b0 : 1'($random(seed));
          @(posedge clk_i);
          if (out_valid_o && out_ready_i) begin
            check_result(exp_res[n_out], result_o);
            check_status(exp_st[n_out], status_o);
            check_tag(tags[n_out], tag_o);
            n_out++;
          end
        end
        if (n_out < 8) begin
          $display("Timeout: only %0d of 8 stalled items came out", n_out);
          tmo_cnt++;
        end
      end
    join
    @(negedge clk_i);
    out_ready_i = 1'b1;
    // Pipeline must now be empty
    for (int n = 0; n < 6; n++) begin
      @(posedge clk_i);
      if (out_valid_o) begin
        $display("An extra result came out after all items were taken");
        err_cnt++;
      end
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    operands_i  = '0;
    op_mod_i    = 1'b0;
    rnd_mode_i  = dotp_pkg::RNE;
    tag_i       = '0;
    out_ready_i = 1'b1;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    test_exact_random();
    test_dotpn();
    test_rounding();
    test_specials();
    test_overflow();
    test_backpressure();

    repeat (2) @(posedge clk_i);
    $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             err_cnt, tmo_cnt, dut.u_props.fail_cnt);
    if (err_cnt == 0 && tmo_cnt == 0 && dut.u_props.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
dotp_pkg.sv
dotp_stage_reg.sv
dotp_decode.sv
dotp_execute.sv
dotp_result.sv
dotp_top.sv
dotp_props.sv
tb_dotp.sv

/* Bender.yml */
package:
  name: dotp

sources:
  - dotp_pkg.sv
  - dotp_stage_reg.sv
  - dotp_decode.sv
  - dotp_execute.sv
  - dotp_result.sv
  - dotp_top.sv
  - target: simulation
    files:
      - dotp_props.sv
      - tb_dotp.sv
